// File: Makefile
VERILATOR ?= verilator
TOP ?= riscvTop_tb
FILELIST ?= riscvTop.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
RUNFLAGS ?= +verilator+error+limit+100
PASS_MSG := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: executeWriteback.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscvCore_defines.svh"

module executeWriteback import riscvPkg::*; (
	input wire CLK,
	input wire RSTn,
	input wire decoded_t decodedOut,
	input wire word_t dMemRdData,
	output dAddr_t dMemAddr,
	output word_t dMemWrData,
	output logic dMemWrEn,
	output logic rfWriteEn,
	output regAddr_t rfWriteAddr,
	output word_t rfWriteData,
	output logic redirect,
	output pc_t redirectPc,
	output logic halt,
	output word_t instCount
);

	logic live;
	logic equal;
	word_t opB;
	word_t aluResult;
	pc_t pcPlus4;

	// the slot captured on the halting edge must not retire
	assign live = decodedOut.valid && !halt;

	assign opB = decodedOut.useImm ? decodedOut.imm : decodedOut.rs2Val;

	always_comb begin
		case (decodedOut.aluOp)
			ALU_ADD: aluResult = decodedOut.rs1Val + opB;
			ALU_SUB: aluResult = decodedOut.rs1Val - opB;
			ALU_AND: aluResult = decodedOut.rs1Val & opB;
			ALU_OR: aluResult = decodedOut.rs1Val | opB;
			ALU_XOR: aluResult = decodedOut.rs1Val ^ opB;
			ALU_SLT: aluResult = word_t'($signed(decodedOut.rs1Val) < $signed(opB));
			ALU_PASSB: aluResult = opB;
			default: aluResult = '0;
		endcase
	end

	// branch and jal
	assign equal = (decodedOut.rs1Val == decodedOut.rs2Val);
	assign redirect = live && (decodedOut.isJal ||
		(decodedOut.isBranch && (equal ^ decodedOut.branchNe)));
	assign redirectPc = decodedOut.pc + decodedOut.imm[`PC_W-1:0];
	assign pcPlus4 = decodedOut.pc + pc_t'(4);

	// byte address from alu, memory is word addressed
	assign dMemAddr = aluResult[`DADDR_W+1:2];
	assign dMemWrData = decodedOut.rs2Val;
	assign dMemWrEn = live && decodedOut.memWrite;

	// x0 writes never leave the stage
	assign rfWriteEn = live && decodedOut.regWrite && (decodedOut.rd != '0);
	assign rfWriteAddr = decodedOut.rd;

	always_comb begin
		if (decodedOut.isJal) begin
			rfWriteData = {{(`XLEN-`PC_W){1'b0}}, pcPlus4};
		end else if (decodedOut.memRead) begin
			rfWriteData = dMemRdData;
		end else begin
			rfWriteData = aluResult;
		end
	end

	// sticky halt
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			halt <= 1'b0;
		end else if (live && decodedOut.isHalt) begin
			halt <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			instCount <= '0;
		end else if (live && !decodedOut.isHalt) begin
			instCount <= instCount + word_t'(1);
		end
	end

endmodule

`default_nettype wire

// File: fetchDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscvCore_defines.svh"

module fetchDecode import riscvPkg::*; (
	input wire CLK,
	input wire RSTn,
	input wire word_t iMemData,
	input wire word_t rs1Data,
	input wire word_t rs2Data,
	input wire redirect,
	input wire pc_t redirectPc,
	input wire halt,
	output pc_t iMemAddr,
	output regAddr_t rs1Addr,
	output regAddr_t rs2Addr,
	output decoded_t decodedIn
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t immI;
	word_t immS;
	word_t immB;
	word_t immU;
	word_t immJ;

	// pc freezes once halted
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			iMemAddr <= `RESET_PC;
		end else if (!halt) begin
			iMemAddr <= redirect ? redirectPc : iMemAddr + pc_t'(4);
		end
	end

	assign opcode = iMemData[6:0];
	assign funct3 = iMemData[14:12];
	assign funct7 = iMemData[31:25];
	assign rs1Addr = iMemData[19:15];
	assign rs2Addr = iMemData[24:20];

	assign immI = {{20{iMemData[31]}}, iMemData[31:20]};
	assign immS = {{20{iMemData[31]}}, iMemData[31:25], iMemData[11:7]};
	assign immB = {{19{iMemData[31]}}, iMemData[31], iMemData[7], iMemData[30:25],
		iMemData[11:8], 1'b0};
	assign immU = {iMemData[31:12], 12'b0};
	assign immJ = {{11{iMemData[31]}}, iMemData[31], iMemData[19:12], iMemData[20],
		iMemData[30:21], 1'b0};

	// anything not recognised falls out as a nop
	always_comb begin
		decodedIn = '0;
		decodedIn.valid = 1'b1;
		decodedIn.pc = iMemAddr;
		decodedIn.rs1Val = rs1Data;
		decodedIn.rs2Val = rs2Data;
		decodedIn.rd = iMemData[11:7];
		decodedIn.aluOp = ALU_ADD;
		case (opcode)
			`OP_RTYPE: begin
				decodedIn.regWrite = 1'b1;
				case (funct3)
					`F3_ADD_SUB: decodedIn.aluOp = (funct7 == `F7_SUB) ? ALU_SUB : ALU_ADD;
					`F3_SLT: decodedIn.aluOp = ALU_SLT;
					`F3_XOR: decodedIn.aluOp = ALU_XOR;
					`F3_OR: decodedIn.aluOp = ALU_OR;
					`F3_AND: decodedIn.aluOp = ALU_AND;
					default: decodedIn.regWrite = 1'b0;
				endcase
			end
			`OP_ITYPE: begin
				decodedIn.regWrite = (funct3 == `F3_ADD_SUB);
				decodedIn.useImm = 1'b1;
				decodedIn.imm = immI;
			end
			`OP_LUI: begin
				decodedIn.regWrite = 1'b1;
				decodedIn.useImm = 1'b1;
				decodedIn.aluOp = ALU_PASSB;
				decodedIn.imm = immU;
			end
			`OP_LOAD: begin
				decodedIn.regWrite = (funct3 == `F3_LW);
				decodedIn.memRead = (funct3 == `F3_LW);
				decodedIn.useImm = 1'b1;
				decodedIn.imm = immI;
			end
			`OP_STORE: begin
				decodedIn.memWrite = (funct3 == `F3_SW);
				decodedIn.useImm = 1'b1;
				decodedIn.imm = immS;
			end
			`OP_BRANCH: begin
				decodedIn.isBranch = (funct3 == `F3_BEQ) || (funct3 == `F3_BNE);
				decodedIn.branchNe = (funct3 == `F3_BNE);
				decodedIn.imm = immB;
			end
			`OP_JAL: begin
				decodedIn.isJal = 1'b1;
				decodedIn.regWrite = 1'b1;
				decodedIn.imm = immJ;
			end
			// ecall only, ebreak and csr forms ignored
			`OP_SYSTEM: decodedIn.isHalt = (iMemData[31:7] == '0);
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: issueStage.sv
`timescale 1ns/1ps
`default_nettype none

module issueStage import riscvPkg::*; (
	input wire CLK,
	input wire RSTn,
	input wire decoded_t decodedIn,
	input wire flush,
	input wire halt,
	output decoded_t decodedOut
);

	decoded_t slot;
	logic slotValid;

	// payload just follows decode
	always_ff @(posedge CLK) begin
		slot <= decodedIn;
	end

	// wrong-path and post-halt slots become bubbles
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			slotValid <= 1'b0;
		end else if (flush || halt) begin
			slotValid <= 1'b0;
		end else begin
			slotValid <= decodedIn.valid;
		end
	end

	always_comb begin
		decodedOut = slot;
		decodedOut.valid = slotValid;
	end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import riscvPkg::*; (
	input wire CLK,
	input wire RSTn,
	input wire regAddr_t rs1Addr,
	input wire regAddr_t rs2Addr,
	input wire writeEn,
	input wire regAddr_t writeAddr,
	input wire word_t writeData,
	output word_t rs1Data,
	output word_t rs2Data
);

	word_t regs [32];

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// write-through covers the producer one slot ahead
	assign rs1Data = (rs1Addr == '0) ? '0 :
		(writeEn && (writeAddr == rs1Addr)) ? writeData : regs[rs1Addr];
	assign rs2Data = (rs2Addr == '0) ? '0 :
		(writeEn && (writeAddr == rs2Addr)) ? writeData : regs[rs2Addr];

endmodule

`default_nettype wire

// File: riscvCore_defines.svh
`ifndef RISCV_CORE_DEFINES_SVH
`define RISCV_CORE_DEFINES_SVH

// datapath and address widths
`define XLEN 32
`define PC_W 12
`define DADDR_W 10
`define RESET_PC 12'h000

// RV32I major opcodes
`define OP_RTYPE 7'b0110011
`define OP_ITYPE 7'b0010011
`define OP_LUI 7'b0110111
`define OP_LOAD 7'b0000011
`define OP_STORE 7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL 7'b1101111
`define OP_SYSTEM 7'b1110011

// funct3 / funct7 values
`define F3_ADD_SUB 3'b000
`define F3_SLT 3'b010
`define F3_XOR 3'b100
`define F3_OR 3'b110
`define F3_AND 3'b111
`define F3_LW 3'b010
`define F3_SW 3'b010
`define F3_BEQ 3'b000
`define F3_BNE 3'b001
`define F7_SUB 7'b0100000

`endif

// File: riscvPkg.sv
`default_nettype none

`include "riscvCore_defines.svh"

package riscvPkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`PC_W-1:0] pc_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [`DADDR_W-1:0] dAddr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASSB
	} aluOp_e;

	// one instruction as it leaves decode
	typedef struct packed {
		logic valid;
		pc_t pc;
		word_t rs1Val;
		word_t rs2Val;
		word_t imm;
		regAddr_t rd;
		aluOp_e aluOp;
		logic useImm;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic isBranch;
		logic branchNe;
		logic isJal;
		logic isHalt;
	} decoded_t;

endpackage

`default_nettype wire

// File: riscvTop.f
+incdir+.
riscvPkg.sv
fetchDecode.sv
regFile.sv
issueStage.sv
executeWriteback.sv
riscvTop.sv
riscvTop_assertions.sv
riscvTop_tb.sv

// File: riscvTop.sv
`timescale 1ns/1ps
`default_nettype none

module riscvTop import riscvPkg::*; (
	input wire CLK,
	input wire RSTn,

	// instruction memory
	output pc_t iMemAddr,
	input wire word_t iMemData,

	// data memory, word addressed
	output dAddr_t dMemAddr,
	output word_t dMemWrData,
	output logic dMemWrEn,
	input wire word_t dMemRdData,

	// register write observation
	output logic rfWriteEn,
	output regAddr_t rfWriteAddr,
	output word_t rfWriteData,
	output logic halt,
	output word_t instCount
);

	regAddr_t rs1Addr;
	regAddr_t rs2Addr;
	word_t rs1Data;
	word_t rs2Data;
	decoded_t decodedIn;
	decoded_t decodedOut;
	logic redirect;
	pc_t redirectPc;

	fetchDecode i_fetchDecode (
		.CLK(CLK),
		.RSTn(RSTn),
		.iMemData(iMemData),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.halt(halt),
		.iMemAddr(iMemAddr),
		.rs1Addr(rs1Addr),
		.rs2Addr(rs2Addr),
		.decodedIn(decodedIn)
	);

	regFile i_regFile (
		.CLK(CLK),
		.RSTn(RSTn),
		.rs1Addr(rs1Addr),
		.rs2Addr(rs2Addr),
		.writeEn(rfWriteEn),
		.writeAddr(rfWriteAddr),
		.writeData(rfWriteData),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

	// redirect doubles as the flush
	issueStage i_issueStage (
		.CLK(CLK),
		.RSTn(RSTn),
		.decodedIn(decodedIn),
		.flush(redirect),
		.halt(halt),
		.decodedOut(decodedOut)
	);

	executeWriteback i_executeWriteback (
		.CLK(CLK),
		.RSTn(RSTn),
		.decodedOut(decodedOut),
		.dMemRdData(dMemRdData),
		.dMemAddr(dMemAddr),
		.dMemWrData(dMemWrData),
		.dMemWrEn(dMemWrEn),
		.rfWriteEn(rfWriteEn),
		.rfWriteAddr(rfWriteAddr),
		.rfWriteData(rfWriteData),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.halt(halt),
		.instCount(instCount)
	);

endmodule

`default_nettype wire

// File: riscvTop_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscvCore_defines.svh"

module riscvTop_assertions import riscvPkg::*; (
	input wire CLK,
	input wire RSTn,
	input wire pc_t iMemAddr,
	input wire dMemWrEn,
	input wire rfWriteEn,
	input wire regAddr_t rfWriteAddr,
	input wire redirect,
	input wire halt
);

	int failCount = 0;

	// first cycle out of reset
	resetState: assert property (@(posedge CLK)
		$fell(RSTn) |-> (iMemAddr == `RESET_PC) && !rfWriteEn && !dMemWrEn && !halt)
	else begin
		failCount++;
		$error("core is not idle at the reset vector after reset");
	end

	noX0Write: assert property (@(posedge CLK) disable iff (RSTn)
		rfWriteEn |-> (rfWriteAddr != '0))
	else begin
		failCount++;
		$error("register write to x0 was seen");
	end

	seqFetch: assert property (@(posedge CLK) disable iff (RSTn)
		(!redirect && !halt) |=> (iMemAddr == $past(iMemAddr) + pc_t'(4)))
	else begin
		failCount++;
		$error("fetch address did not step by four");
	end

	// halt is sticky and freezes everything
	haltSticky: assert property (@(posedge CLK) disable iff (RSTn)
		halt |=> halt)
	else begin
		failCount++;
		$error("halt dropped after it was set");
	end

	haltFreeze: assert property (@(posedge CLK) disable iff (RSTn)
		halt |=> (iMemAddr == $past(iMemAddr)))
	else begin
		failCount++;
		$error("fetch address moved while halted");
	end

	haltQuiet: assert property (@(posedge CLK) disable iff (RSTn)
		halt |-> (!rfWriteEn && !dMemWrEn))
	else begin
		failCount++;
		$error("write seen while halted");
	end

endmodule

bind riscvTop riscvTop_assertions i_assertions (
	.CLK(CLK),
	.RSTn(RSTn),
	.iMemAddr(iMemAddr),
	.dMemWrEn(dMemWrEn),
	.rfWriteEn(rfWriteEn),
	.rfWriteAddr(rfWriteAddr),
	.redirect(redirect),
	.halt(halt)
);

`default_nettype wire

// File: riscvTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscvCore_defines.svh"

module riscvTop_tb import riscvPkg::*; ();

	// about 40 cycles for reset, program and tail, so 200 is ample
	localparam int TIMEOUT = 200;
	// 15 straight-line, then 16, 18 to 21 and 23; ecall not counted
	localparam int EXP_COUNT = 21;

	typedef struct packed {
		regAddr_t addr;
		word_t data;
	} rfWrite_t;

	typedef struct packed {
		dAddr_t addr;
		word_t data;
	} memWrite_t;

	logic CLK;
	logic RSTn;
	pc_t iMemAddr;
	word_t iMemData = '0;
	dAddr_t dMemAddr;
	word_t dMemWrData;
	logic dMemWrEn;
	word_t dMemRdData = '0;
	logic rfWriteEn;
	regAddr_t rfWriteAddr;
	word_t rfWriteData;
	logic halt;
	word_t instCount;

	word_t iMem [64];
	word_t dMem [256];
	rfWrite_t expWrites [$];
	memWrite_t expStores [$];
	int wrIdx = 0;
	int stIdx = 0;
	int writeErrors = 0;
	int endErrors = 0;
	int cycles = 0;

	riscvTop i_riscvTop (
		.CLK(CLK),
		.RSTn(RSTn),
		.iMemAddr(iMemAddr),
		.iMemData(iMemData),
		.dMemAddr(dMemAddr),
		.dMemWrData(dMemWrData),
		.dMemWrEn(dMemWrEn),
		.dMemRdData(dMemRdData),
		.rfWriteEn(rfWriteEn),
		.rfWriteAddr(rfWriteAddr),
		.rfWriteData(rfWriteData),
		.halt(halt),
		.instCount(instCount)
	);

	function automatic word_t encR(input logic [6:0] f7, input regAddr_t rs2,
		input regAddr_t rs1, input logic [2:0] f3, input regAddr_t rd);
		return {f7, rs2, rs1, f3, rd, `OP_RTYPE};
	endfunction

	function automatic word_t encI(input logic [11:0] imm, input regAddr_t rs1,
		input logic [2:0] f3, input regAddr_t rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t encU(input logic [19:0] imm, input regAddr_t rd);
		return {imm, rd, `OP_LUI};
	endfunction

	function automatic word_t encS(input logic [11:0] imm, input regAddr_t rs2,
		input regAddr_t rs1);
		return {imm[11:5], rs2, rs1, `F3_SW, imm[4:0], `OP_STORE};
	endfunction

	function automatic word_t encB(input logic [12:0] imm, input regAddr_t rs2,
		input regAddr_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
	endfunction

	function automatic word_t encJ(input logic [20:0] imm, input regAddr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
	endfunction

	function automatic int checkValue(input string name, input word_t got,
		input word_t expected);
		if (got !== expected) begin
			$display("ERR %s: got %h expected %h", name, got, expected);
			return 1;
		end
		return 0;
	endfunction

	task automatic loadProgram();
		// unused words are nops with the word index as immediate
		for (int i = 0; i < 64; i++) begin
			iMem[i] = encI(12'(i), 5'd0, `F3_ADD_SUB, 5'd0, `OP_ITYPE);
		end
		iMem[0] = encI(12'd5, 5'd0, `F3_ADD_SUB, 5'd1, `OP_ITYPE);     // addi x1, x0, 5
		iMem[1] = encI(12'hFFD, 5'd1, `F3_ADD_SUB, 5'd2, `OP_ITYPE);   // addi x2, x1, -3
		iMem[2] = encU(20'h12345, 5'd3);                                // lui x3, 0x12345
		iMem[3] = encR(7'd0, 5'd2, 5'd3, `F3_ADD_SUB, 5'd4);            // add x4, x3, x2
		iMem[4] = encR(`F7_SUB, 5'd1, 5'd4, `F3_ADD_SUB, 5'd5);         // sub x5, x4, x1
		iMem[5] = encR(7'd0, 5'd3, 5'd5, `F3_AND, 5'd6);                // and x6, x5, x3
		iMem[6] = encR(7'd0, 5'd1, 5'd6, `F3_OR, 5'd7);                 // or x7, x6, x1
		iMem[7] = encR(7'd0, 5'd4, 5'd7, `F3_XOR, 5'd8);                // xor x8, x7, x4
		iMem[8] = encI(12'hFFF, 5'd0, `F3_ADD_SUB, 5'd9, `OP_ITYPE);   // addi x9, x0, -1
		iMem[9] = encR(7'd0, 5'd1, 5'd9, `F3_SLT, 5'd10);               // slt x10, x9, x1
		iMem[10] = encR(7'd0, 5'd9, 5'd1, `F3_SLT, 5'd11);              // slt x11, x1, x9
		iMem[11] = encI(12'd7, 5'd1, `F3_ADD_SUB, 5'd0, `OP_ITYPE);    // addi x0, x1, 7
		iMem[12] = encS(12'd14, 5'd8, 5'd2);                            // sw x8, 14(x2)
		iMem[13] = encI(12'd16, 5'd0, `F3_LW, 5'd12, `OP_LOAD);         // lw x12, 16(x0)
		iMem[14] = encB(13'd8, 5'd1, 5'd1, `F3_BEQ);                    // beq x1, x1, +8
		iMem[15] = encI(12'd99, 5'd0, `F3_ADD_SUB, 5'd13, `OP_ITYPE);  // addi x13 (skipped)
		iMem[16] = encB(13'd8, 5'd2, 5'd1, `F3_BNE);                    // bne x1, x2, +8
		iMem[17] = encI(12'd98, 5'd0, `F3_ADD_SUB, 5'd13, `OP_ITYPE);  // addi x13 (skipped)
		iMem[18] = encB(13'd8, 5'd2, 5'd1, `F3_BEQ);                    // beq x1, x2 not taken
		iMem[19] = encI(12'd1, 5'd12, `F3_ADD_SUB, 5'd14, `OP_ITYPE);  // addi x14, x12, 1
		iMem[20] = encB(13'd8, 5'd1, 5'd1, `F3_BNE);                    // bne x1, x1 not taken
		iMem[21] = encJ(21'd8, 5'd15);                                  // jal x15, +8
		iMem[22] = encI(12'd97, 5'd0, `F3_ADD_SUB, 5'd13, `OP_ITYPE);  // addi x13 (skipped)
		iMem[23] = encR(7'd0, 5'd14, 5'd15, `F3_ADD_SUB, 5'd16);        // add x16, x15, x14
		iMem[24] = encI(12'd0, 5'd0, 3'd0, 5'd0, `OP_SYSTEM);           // ecall
		iMem[25] = encI(12'd1, 5'd0, `F3_ADD_SUB, 5'd17, `OP_ITYPE);   // addi x17 (never retires)
	endtask

	task automatic loadExpected();
		expWrites.push_back({5'd1, 32'h00000005});
		expWrites.push_back({5'd2, 32'h00000002});
		expWrites.push_back({5'd3, 32'h12345000});
		expWrites.push_back({5'd4, 32'h12345002});
		expWrites.push_back({5'd5, 32'h12344FFD});
		expWrites.push_back({5'd6, 32'h12344000});
		expWrites.push_back({5'd7, 32'h12344005});
		expWrites.push_back({5'd8, 32'h00001007});
		expWrites.push_back({5'd9, 32'hFFFFFFFF});
		expWrites.push_back({5'd10, 32'h00000001});
		expWrites.push_back({5'd11, 32'h00000000});
		expWrites.push_back({5'd12, 32'h00001007});
		expWrites.push_back({5'd14, 32'h00001008});
		// jal at byte 84 links 88
		expWrites.push_back({5'd15, 32'h00000058});
		expWrites.push_back({5'd16, 32'h00001060});
		// byte 16 is word 4
		expStores.push_back({10'd4, 32'h00001007});
	endtask

	task automatic printCounts();
		$display("errors: %0d write, %0d end, %0d assertion", writeErrors, endErrors,
			i_riscvTop.i_assertions.failCount);
	endtask

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// memories answer within the cycle
	always @(negedge CLK) begin
		iMemData <= iMem[iMemAddr[7:2]];
		dMemRdData <= dMem[dMemAddr[7:0]];
	end

	always @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < 256; i++) begin
				dMem[i] <= 32'hDA7A0000 | 32'(i);
			end
		end else if (dMemWrEn) begin
			dMem[dMemAddr[7:0]] <= dMemWrData;
		end
	end

	// compare each retiring write with the next table entry
	always @(posedge CLK) begin
		if (!RSTn && rfWriteEn) begin
			if (wrIdx >= expWrites.size()) begin
				$display("unexpected register write to x%0d", rfWriteAddr);
				writeErrors++;
			end else begin
				writeErrors += checkValue("rfWriteAddr", word_t'(rfWriteAddr),
					word_t'(expWrites[wrIdx].addr));
				writeErrors += checkValue("rfWriteData", rfWriteData, expWrites[wrIdx].data);
			end
			wrIdx++;
		end
		if (!RSTn && dMemWrEn) begin
			if (stIdx >= expStores.size()) begin
				$display("unexpected data memory write at word %0d", dMemAddr);
				writeErrors++;
			end else begin
				writeErrors += checkValue("dMemAddr", word_t'(dMemAddr),
					word_t'(expStores[stIdx].addr));
				writeErrors += checkValue("dMemWrData", dMemWrData, expStores[stIdx].data);
			end
			stIdx++;
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("timeout: core did not halt within %0d cycles", TIMEOUT);
			printCounts();
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		RSTn = 1'b1;
		loadProgram();
		loadExpected();
		repeat (5) @(negedge CLK);
		RSTn = 1'b0;
		while (halt !== 1'b1) begin
			@(negedge CLK);
		end
		// a few cycles past halt for the bound checks
		repeat (4) @(negedge CLK);
		endErrors += checkValue("instCount", instCount, word_t'(EXP_COUNT));
		if (wrIdx != expWrites.size()) begin
			$display("saw %0d register writes but expected %0d", wrIdx, expWrites.size());
			endErrors++;
		end
		if (stIdx != expStores.size()) begin
			$display("saw %0d stores but expected %0d", stIdx, expStores.size());
			endErrors++;
		end
		printCounts();
		if (writeErrors + endErrors + i_riscvTop.i_assertions.failCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
